// File: Makefile
# Verilator build and run for the decode stage testbench
VERILATOR ?= verilator
TOP ?= decodeTb
FILELIST ?= decodeCore.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
EXTRA_FLAGS ?=

BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# $fatal in the testbench gives a nonzero exit status
run: compile
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: decodeCore.f
design/decodeTypesPkg.sv
design/decodeCfgPkg.sv
design/microOpPicker.sv
design/branchResolver.sv
design/decodeStage.sv
design/decodeCsr.sv
design/decodeTop.sv
testbench/decodeTb.sv

// File: design/branchResolver.sv
/*
 * Early resolution of direct unconditional jumps.
 * Only the oldest mispredicted jump counts; younger lanes are cancelled.
 * A repeated request for the same jump is reported only once.
 */
`timescale 1ns/100ps

module branchResolver (
    input  logic clk,
    input  logic rstN,
    input  decodeTypesPkg::DecodeBundle lanes,
    input  logic enable,
    output logic laneValidOut [decodeTypesPkg::DECODE_WIDTH],
    output decodeTypesPkg::Redirect redirect
);

    logic request;
    logic firedQ;
    decodeTypesPkg::PcPath jumpPc;
    decodeTypesPkg::PcPath firedPcQ;
    decodeTypesPkg::PcPath target;

    always_comb begin
        logic cancel;

        cancel = 1'b0;
        request = 1'b0;
        jumpPc = '0;
        target = '0;
        for (int i = 0; i < decodeTypesPkg::DECODE_WIDTH; i++) begin
            laneValidOut[i] = lanes[i].valid && !cancel;
            if (enable && laneValidOut[i] && lanes[i].isJump && !request) begin
                if (!lanes[i].brPred.predTaken ||
                        lanes[i].brPred.predTarget != lanes[i].jumpTarget) begin
                    request = 1'b1;
                    jumpPc = lanes[i].pc;
                    target = lanes[i].jumpTarget;
                    cancel = 1'b1;
                end
            end
        end
        redirect.flush = request && !(firedQ && firedPcQ == jumpPc);
        redirect.recoveredPc = target;
    end

    // Remembers the jump already reported while the bundle drains
    always_ff @(posedge clk) begin
        if (!rstN) begin
            firedQ <= 1'b0;
            firedPcQ <= '0;
        end else begin
            firedQ <= request;
            if (request) begin
                firedPcQ <= jumpPc;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        redirect.flush |-> (lanes[0].valid && lanes[0].isJump) ||
                           (lanes[1].valid && lanes[1].isJump))
        else $error("flush without a valid jump lane");

endmodule

// File: design/decodeCfgPkg.sv
/*
 * APB configuration port types and register map.
 * Byte addresses, 32-bit data, no wait states.
 */
package decodeCfgPkg;

    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;

    localparam logic [APB_ADDR_WIDTH-1:0] CTRL_ADDR = 8'h00;
    localparam logic [APB_ADDR_WIDTH-1:0] PICKED_ADDR = 8'h04;
    localparam logic [APB_ADDR_WIDTH-1:0] REDIRECT_ADDR = 8'h08;

    // CTRL bit positions
    localparam int CTRL_SERIALIZE_BIT = 0;
    localparam int CTRL_RESOLVER_BIT = 1;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [APB_ADDR_WIDTH-1:0] paddr;
        logic [APB_DATA_WIDTH-1:0] pwdata;
    } ApbReq;

    typedef struct packed {
        logic [APB_DATA_WIDTH-1:0] prdata;
        logic pready;
        logic pslverr;
    } ApbRsp;

    typedef struct packed {
        logic serializeAll;
        logic resolverEnable;
    } DecodeCfg;

endpackage

// File: design/decodeCsr.sv
/*
 * APB slave for decode stage control and event counters.
 * pready is tied high. Unknown addresses read zero with pslverr.
 * Counters saturate at all ones and clear on any write.
 */
`timescale 1ns/100ps

module decodeCsr (
    input  logic clk,
    input  logic rstN,
    input  decodeCfgPkg::ApbReq apbReq,
    output decodeCfgPkg::ApbRsp apbRsp,
    output decodeCfgPkg::DecodeCfg cfg,
    input  decodeTypesPkg::DecodeEvents events
);

    localparam int DW = decodeCfgPkg::APB_DATA_WIDTH;

    logic access;
    logic wrCtrl;
    logic wrPicked;
    logic wrRedirect;
    logic knownAddr;
    logic [DW-1:0] pickedCntQ;
    logic [DW-1:0] redirCntQ;
    logic [DW:0] pickedSum;
    logic [DW:0] redirSum;

    assign access = apbReq.psel && apbReq.penable;
    assign wrCtrl = access && apbReq.pwrite && apbReq.paddr == decodeCfgPkg::CTRL_ADDR;
    assign wrPicked = access && apbReq.pwrite && apbReq.paddr == decodeCfgPkg::PICKED_ADDR;
    assign wrRedirect = access && apbReq.pwrite &&
        apbReq.paddr == decodeCfgPkg::REDIRECT_ADDR;

    assign pickedSum = {1'b0, pickedCntQ} + (DW+1)'(events.pickedCount);
    assign redirSum = {1'b0, redirCntQ} + (DW+1)'(events.redirect);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cfg.serializeAll <= 1'b0;
            cfg.resolverEnable <= 1'b1;
        end else if (wrCtrl) begin
            cfg.serializeAll <= apbReq.pwdata[decodeCfgPkg::CTRL_SERIALIZE_BIT];
            cfg.resolverEnable <= apbReq.pwdata[decodeCfgPkg::CTRL_RESOLVER_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || wrPicked) begin
            pickedCntQ <= '0;
        end else begin
            pickedCntQ <= pickedSum[DW] ? '1 : pickedSum[DW-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || wrRedirect) begin
            redirCntQ <= '0;
        end else begin
            redirCntQ <= redirSum[DW] ? '1 : redirSum[DW-1:0];
        end
    end

    always_comb begin
        knownAddr = 1'b1;
        apbRsp.prdata = '0;
        case (apbReq.paddr)
            decodeCfgPkg::CTRL_ADDR: begin
                apbRsp.prdata[decodeCfgPkg::CTRL_SERIALIZE_BIT] = cfg.serializeAll;
                apbRsp.prdata[decodeCfgPkg::CTRL_RESOLVER_BIT] = cfg.resolverEnable;
            end
            decodeCfgPkg::PICKED_ADDR: apbRsp.prdata = pickedCntQ;
            decodeCfgPkg::REDIRECT_ADDR: apbRsp.prdata = redirCntQ;
            default: knownAddr = 1'b0;
        endcase
        apbRsp.pready = 1'b1;
        apbRsp.pslverr = access && !knownAddr;
    end

    assert property (@(posedge clk) disable iff (!rstN)
        apbReq.penable |-> apbReq.psel)
        else $error("APB penable without psel");

endmodule

// File: design/decodeStage.sv
/*
 * Decode pipeline register with multi-cycle drain of micro-ops.
 * A new bundle is taken only once the held one completes without stall.
 * outStall freezes all state, so issue holds steady while it is high.
 */
`timescale 1ns/100ps

module decodeStage (
    input  logic clk,
    input  logic rstN,
    input  decodeTypesPkg::DecodeBundle inBundle,
    input  logic inValid,
    output logic inReady,
    output decodeTypesPkg::IssueSlot issue [decodeTypesPkg::DECODE_WIDTH],
    input  logic outStall,
    output decodeTypesPkg::Redirect redirect,
    input  decodeCfgPkg::DecodeCfg cfg,
    output decodeTypesPkg::DecodeEvents events
);

    localparam int LANES = decodeTypesPkg::DECODE_WIDTH;
    localparam int MOPS = decodeTypesPkg::MICRO_OP_MAX_NUM;
    localparam int SLOTS = decodeTypesPkg::ALL_MICRO_OP_WIDTH;

    decodeTypesPkg::DecodeBundle bundleQ;
    logic initiateQ;
    decodeTypesPkg::MopMask remainingQ;
    logic flushPendQ;
    decodeTypesPkg::PcPath recPcQ;

    decodeTypesPkg::MicroOp mopArr [SLOTS];
    decodeTypesPkg::MopMask curPending;
    decodeTypesPkg::MopMask serialMask;
    decodeTypesPkg::MopMask remaining;
    decodeTypesPkg::MopMask unpicked;
    logic picked [LANES];
    decodeTypesPkg::MicroOpIndex pickedIndex [LANES];
    logic laneValid [LANES];
    decodeTypesPkg::Redirect resRedirect;
    logic complete;
    logic flushNow;

    branchResolver resolver_i (
        .clk(clk),
        .rstN(rstN),
        .lanes(bundleQ),
        .enable(cfg.resolverEnable),
        .laneValidOut(laneValid),
        .redirect(resRedirect)
    );

    // Slot view of the held bundle, cancelled lanes dropped from pending
    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            mopArr[s] = bundleQ[s / MOPS].mops[s % MOPS];
            serialMask[s] = mopArr[s].serialized || cfg.serializeAll;
            if (initiateQ) begin
                curPending[s] = mopArr[s].valid;
            end else begin
                curPending[s] = remainingQ[s];
            end
            curPending[s] = curPending[s] && laneValid[s / MOPS];
        end
    end

    microOpPicker picker_i (
        .pending(curPending),
        .serialize(serialMask),
        .picked(picked),
        .pickedIndex(pickedIndex),
        .remaining(remaining)
    );

    always_comb begin
        int lane;

        complete = (remaining == '0);
        inReady = complete && !outStall && rstN;
        flushNow = complete && !outStall && (flushPendQ || resRedirect.flush);
        redirect.flush = flushNow;
        redirect.recoveredPc = resRedirect.flush ? resRedirect.recoveredPc : recPcQ;

        for (int i = 0; i < LANES; i++) begin
            lane = int'(pickedIndex[i]) / MOPS;
            issue[i].valid = picked[i];
            issue[i].mop = mopArr[pickedIndex[i]];
            issue[i].pc = bundleQ[lane].pc;
            issue[i].brPred = bundleQ[lane].brPred;
        end

        events.pickedCount = outStall ? 2'd0 :
            2'(picked[0]) + 2'(picked[1]);
        events.redirect = flushNow;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            bundleQ <= '0;
            initiateQ <= 1'b1;
            remainingQ <= '0;
        end else if (!outStall) begin
            if (complete) begin
                // Empty register when nothing is offered
                bundleQ <= inValid ? inBundle : '0;
                initiateQ <= 1'b1;
                remainingQ <= '0;
            end else begin
                initiateQ <= 1'b0;
                remainingQ <= remaining;
            end
        end
    end

    // Redirect request seen early is held until the bundle completes
    always_ff @(posedge clk) begin
        if (!rstN) begin
            flushPendQ <= 1'b0;
            recPcQ <= '0;
        end else if (complete && !outStall) begin
            flushPendQ <= 1'b0;
        end else if (resRedirect.flush) begin
            flushPendQ <= 1'b1;
            recPcQ <= resRedirect.recoveredPc;
        end
    end

    // Pending slots that neither output lane takes this cycle
    always_comb begin
        unpicked = curPending;
        for (int i = 0; i < LANES; i++) begin
            if (picked[i]) begin
                unpicked[pickedIndex[i]] = 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        inReady |-> unpicked == '0)
        else $error("bundle accepted while micro-ops still pending");

endmodule

// File: design/decodeTop.sv
/*
 * Decode stage top with its APB configuration block.
 * Configuration writes apply from the cycle after the access.
 */
`timescale 1ns/100ps

module decodeTop (
    input  logic clk,
    input  logic rstN,
    input  decodeTypesPkg::DecodeBundle inBundle,
    input  logic inValid,
    output logic inReady,
    output decodeTypesPkg::IssueSlot issue [decodeTypesPkg::DECODE_WIDTH],
    input  logic outStall,
    output decodeTypesPkg::Redirect redirect,
    input  decodeCfgPkg::ApbReq apbReq,
    output decodeCfgPkg::ApbRsp apbRsp
);

    decodeCfgPkg::DecodeCfg cfg;
    decodeTypesPkg::DecodeEvents events;

    decodeStage stage_i (
        .clk(clk),
        .rstN(rstN),
        .inBundle(inBundle),
        .inValid(inValid),
        .inReady(inReady),
        .issue(issue),
        .outStall(outStall),
        .redirect(redirect),
        .cfg(cfg),
        .events(events)
    );

    decodeCsr csr_i (
        .clk(clk),
        .rstN(rstN),
        .apbReq(apbReq),
        .apbRsp(apbRsp),
        .cfg(cfg),
        .events(events)
    );

endmodule

// File: design/decodeTypesPkg.sv
/*
 * Types shared by the decode pipeline modules.
 * Micro-ops arrive pre-decoded, two per instruction and two lanes per bundle.
 * Lane 0 is the oldest instruction of a bundle.
 */
package decodeTypesPkg;

    localparam int DECODE_WIDTH = 2;
    localparam int MICRO_OP_MAX_NUM = 2;
    localparam int ALL_MICRO_OP_WIDTH = DECODE_WIDTH * MICRO_OP_MAX_NUM;
    localparam int PC_WIDTH = 32;
    localparam int OP_CLASS_WIDTH = 4;
    localparam int OPERAND_WIDTH = 8;

    typedef logic [$clog2(ALL_MICRO_OP_WIDTH)-1:0] MicroOpIndex;
    typedef logic [ALL_MICRO_OP_WIDTH-1:0] MopMask;
    typedef logic [PC_WIDTH-1:0] PcPath;

    typedef struct packed {
        logic valid;
        logic serialized;
        // Position inside the instruction
        logic mid;
        logic [OP_CLASS_WIDTH-1:0] opClass;
        logic [OPERAND_WIDTH-1:0] operand;
    } MicroOp;

    typedef struct packed {
        logic predTaken;
        PcPath predTarget;
    } BranchPred;

    typedef struct packed {
        logic valid;
        PcPath pc;
        // Direct unconditional jump
        logic isJump;
        PcPath jumpTarget;
        BranchPred brPred;
        MicroOp [MICRO_OP_MAX_NUM-1:0] mops;
    } InsnLane;

    typedef InsnLane [DECODE_WIDTH-1:0] DecodeBundle;

    typedef struct packed {
        logic valid;
        MicroOp mop;
        PcPath pc;
        BranchPred brPred;
    } IssueSlot;

    typedef struct packed {
        logic flush;
        PcPath recoveredPc;
    } Redirect;

    typedef struct packed {
        // Micro-ops leaving this cycle, 0 to 2
        logic [1:0] pickedCount;
        logic redirect;
    } DecodeEvents;

endpackage

// File: design/microOpPicker.sv
/*
 * Picks up to two pending micro-ops in slot order.
 * A serialized micro-op leaves alone and ends the scan.
 */
`timescale 1ns/100ps

module microOpPicker (
    input  decodeTypesPkg::MopMask pending,
    input  decodeTypesPkg::MopMask serialize,
    output logic picked [decodeTypesPkg::DECODE_WIDTH],
    output decodeTypesPkg::MicroOpIndex pickedIndex [decodeTypesPkg::DECODE_WIDTH],
    output decodeTypesPkg::MopMask remaining
);

    always_comb begin
        decodeTypesPkg::MopMask cur;
        logic stop;
        logic sent;
        logic found;

        cur = pending;
        stop = 1'b0;
        sent = 1'b0;
        for (int i = 0; i < decodeTypesPkg::DECODE_WIDTH; i++) begin
            picked[i] = 1'b0;
            pickedIndex[i] = '0;
            found = 1'b0;
            for (int s = 0; s < decodeTypesPkg::ALL_MICRO_OP_WIDTH; s++) begin
                if (cur[s] && !found && !stop) begin
                    found = 1'b1;
                    if (serialize[s]) begin
                        stop = 1'b1;
                    end
                    // Serialized op behind a normal one waits a cycle
                    if (!(serialize[s] && sent)) begin
                        sent = 1'b1;
                        picked[i] = 1'b1;
                        pickedIndex[i] = decodeTypesPkg::MicroOpIndex'(s);
                        cur[s] = 1'b0;
                    end
                end
            end
        end
        remaining = cur;
    end

    always_comb begin
        if (picked[0] && picked[1]) begin
            assert (pickedIndex[0] != pickedIndex[1])
                else $error("picker chose slot %0d twice", pickedIndex[0]);
        end
    end

endmodule

// File: testbench/decodeTb.sv
/*
 * Random bundle testbench for decodeTop with a reference queue of micro-ops.
 * CTRL is only changed while the stage is idle, and bundle pcs never repeat.
 * Runs 300 bundles in three phases of configuration.
 */
`timescale 1ns/100ps

module decodeTb;

    localparam int TOTAL_BUNDLES = 300;
    localparam int CYCLE_LIMIT = 40 * TOTAL_BUNDLES + 2000;

    typedef struct packed {
        decodeTypesPkg::PcPath pc;
        decodeTypesPkg::BranchPred brPred;
        decodeTypesPkg::MicroOp mop;
    } ExpOp;

    logic clk;
    logic rstN;
    decodeTypesPkg::DecodeBundle inBundle;
    logic inValid;
    logic inReady;
    decodeTypesPkg::IssueSlot issue [decodeTypesPkg::DECODE_WIDTH];
    logic outStall;
    decodeTypesPkg::Redirect redirect;
    decodeCfgPkg::ApbReq apbReq;
    decodeCfgPkg::ApbRsp apbRsp;

    logic [31:0] rngState = 32'hfd57921d;
    string testName = "reset";
    logic serialMode = 1'b0;
    logic resolverMode = 1'b1;
    ExpOp expQ [$];
    decodeTypesPkg::PcPath flushQ [$];
    int accepted = 0;
    int bundleSeq = 0;
    int pickedTotal = 0;
    int flushTotal = 0;
    int cycleCount = 0;
    logic lastReady = 1'b0;
    logic expHas0 = 1'b0;
    logic expHas1 = 1'b0;
    ExpOp expOp0 = '0;
    ExpOp expOp1 = '0;
    logic expFlushHas = 1'b0;
    decodeTypesPkg::PcPath expFlushPc = '0;
    ExpOp gotOp0;
    ExpOp gotOp1;
    logic [2*$bits(decodeTypesPkg::IssueSlot)-1:0] issueBits;

    decodeTop dut_i (
        .clk(clk),
        .rstN(rstN),
        .inBundle(inBundle),
        .inValid(inValid),
        .inReady(inReady),
        .issue(issue),
        .outStall(outStall),
        .redirect(redirect),
        .apbReq(apbReq),
        .apbRsp(apbRsp)
    );

    assign gotOp0 = {issue[0].pc, issue[0].brPred, issue[0].mop};
    assign gotOp1 = {issue[1].pc, issue[1].brPred, issue[1].mop};
    assign issueBits = {issue[1], issue[0]};

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic decodeTypesPkg::DecodeBundle makeBundle(input decodeTypesPkg::PcPath base);
        decodeTypesPkg::DecodeBundle b;
        logic [31:0] r;
        logic [31:0] t;
        b = '0;
        for (int l = 0; l < decodeTypesPkg::DECODE_WIDTH; l++) begin
            r = nextRand();
            t = nextRand();
            b[l].valid = r[2:0] != 3'd0;
            b[l].pc = base + decodeTypesPkg::PcPath'(4 * l);
            b[l].isJump = r[4:3] == 2'd0;
            b[l].jumpTarget = {t[31:2], 2'b00};
            b[l].brPred.predTaken = r[5];
            // Wrong target in about a quarter of the jumps
            b[l].brPred.predTarget = r[7:6] == 2'd0 ? b[l].jumpTarget + 32'h40 : b[l].jumpTarget;
            for (int m = 0; m < decodeTypesPkg::MICRO_OP_MAX_NUM; m++) begin
                r = nextRand();
                b[l].mops[m].valid = r[1:0] != 2'd0;
                b[l].mops[m].serialized = r[4:2] == 3'd0;
                b[l].mops[m].mid = 1'(m);
                b[l].mops[m].opClass = r[11:8];
                b[l].mops[m].operand = r[19:12];
            end
        end
        return b;
    endfunction

    // Slot order is lane order, then micro-op order inside the lane
    function automatic void pushExpected(input decodeTypesPkg::DecodeBundle b);
        logic cancel;
        ExpOp e;
        cancel = 1'b0;
        for (int l = 0; l < decodeTypesPkg::DECODE_WIDTH; l++) begin
            if (b[l].valid && !cancel) begin
                for (int m = 0; m < decodeTypesPkg::MICRO_OP_MAX_NUM; m++) begin
                    if (b[l].mops[m].valid) begin
                        e.pc = b[l].pc;
                        e.brPred = b[l].brPred;
                        e.mop = b[l].mops[m];
                        expQ.push_back(e);
                    end
                end
                if (resolverMode && b[l].isJump && (!b[l].brPred.predTaken ||
                        b[l].brPred.predTarget != b[l].jumpTarget)) begin
                    cancel = 1'b1;
                    flushQ.push_back(b[l].jumpTarget);
                end
            end
        end
    endfunction

    // Bookkeeping in mid cycle, where DUT outputs are settled
    always @(negedge clk) begin
        if (rstN) begin
            expHas0 = expQ.size() > 0;
            expHas1 = expQ.size() > 1;
            expOp0 = expHas0 ? expQ[0] : '0;
            expOp1 = expHas1 ? expQ[1] : '0;
            expFlushHas = flushQ.size() > 0;
            expFlushPc = expFlushHas ? flushQ[0] : '0;
            if (!outStall) begin
                for (int i = 0; i < decodeTypesPkg::DECODE_WIDTH; i++) begin
                    if (issue[i].valid && expQ.size() > 0) begin
                        void'(expQ.pop_front());
                        pickedTotal++;
                    end
                end
            end
            if (redirect.flush) begin
                flushTotal++;
                if (flushQ.size() > 0) begin
                    void'(flushQ.pop_front());
                end
            end
            if (inValid && inReady) begin
                pushExpected(inBundle);
                accepted++;
            end
            lastReady = inReady;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            failRun($sformatf("timeout after %0d cycles in test %s", cycleCount, testName));
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        issue[0].valid |-> expHas0 && gotOp0 == expOp0)
        else failRun($sformatf("mismatch %s lane 0 expected %h actual %h",
            testName, $sampled(expOp0), $sampled(gotOp0)));

    assert property (@(posedge clk) disable iff (!rstN)
        issue[1].valid |-> expHas1 && gotOp1 == expOp1)
        else failRun($sformatf("mismatch %s lane 1 expected %h actual %h",
            testName, $sampled(expOp1), $sampled(gotOp1)));

    assert property (@(posedge clk) disable iff (!rstN)
        issue[1].valid |-> issue[0].valid && !serialMode &&
            !issue[0].mop.serialized && !issue[1].mop.serialized)
        else failRun($sformatf("test %s issued a serialized micro-op beside another", testName));

    assert property (@(posedge clk) disable iff (!rstN) outStall |-> !inReady)
        else failRun($sformatf("test %s saw inReady high during a stall", testName));

    assert property (@(posedge clk) disable iff (!rstN) outStall |=> $stable(issueBits))
        else failRun($sformatf("test %s saw issue slots change under a stall", testName));

    assert property (@(posedge clk) disable iff (!rstN)
        redirect.flush |-> expFlushHas && redirect.recoveredPc == expFlushPc)
        else failRun($sformatf("mismatch %s flush expected %0b/%h actual 1/%h", testName,
            $sampled(expFlushHas), $sampled(expFlushPc), $sampled(redirect.recoveredPc)));

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #10;
        apbReq.psel = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite = 1'b1;
        apbReq.paddr = addr;
        apbReq.pwdata = data;
        @(posedge clk);
        #10;
        apbReq.penable = 1'b1;
        @(posedge clk);
        #10;
        apbReq = '0;
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        #10;
        apbReq.psel = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite = 1'b0;
        apbReq.paddr = addr;
        @(posedge clk);
        #10;
        apbReq.penable = 1'b1;
        @(negedge clk);
        data = apbRsp.prdata;
        err = apbRsp.pslverr;
        assert (apbRsp.pready)
            else failRun($sformatf("test %s saw pready low in an APB access phase", testName));
        @(posedge clk);
        #10;
        apbReq = '0;
    endtask

    task automatic setCtrl(input logic serial, input logic resolver);
        logic [31:0] wdata;
        logic [31:0] data;
        logic err;
        wdata = '0;
        wdata[decodeCfgPkg::CTRL_SERIALIZE_BIT] = serial;
        wdata[decodeCfgPkg::CTRL_RESOLVER_BIT] = resolver;
        apbWrite(decodeCfgPkg::CTRL_ADDR, wdata);
        apbRead(decodeCfgPkg::CTRL_ADDR, data, err);
        assert (!err && data == wdata)
            else failRun($sformatf("mismatch %s CTRL expected %h actual %h", testName, wdata, data));
        serialMode = serial;
        resolverMode = resolver;
    endtask

    task automatic checkCounters();
        logic [31:0] data;
        logic err;
        apbRead(decodeCfgPkg::PICKED_ADDR, data, err);
        assert (!err && data == 32'(pickedTotal))
            else failRun($sformatf("mismatch %s PICKED expected %0d actual %0d",
                testName, pickedTotal, data));
        apbRead(decodeCfgPkg::REDIRECT_ADDR, data, err);
        assert (!err && data == 32'(flushTotal))
            else failRun($sformatf("mismatch %s REDIRECT expected %0d actual %0d",
                testName, flushTotal, data));
    endtask

    // A bundle is held on inBundle until the handshake takes it
    task automatic runBundles(input int count);
        int goal;
        int seen;
        goal = accepted + count;
        seen = accepted;
        while (accepted < goal) begin
            @(posedge clk);
            #10;
            outStall = (nextRand() % 4) == 0;
            if (!inValid || accepted != seen) begin
                seen = accepted;
                if (accepted < goal && (nextRand() % 5) != 0) begin
                    inBundle = makeBundle(32'h1000 + decodeTypesPkg::PcPath'(16 * bundleSeq));
                    bundleSeq++;
                    inValid = 1'b1;
                end else begin
                    inValid = 1'b0;
                end
            end
        end
        inValid = 1'b0;
    endtask

    // inReady without stall marks the last picks of the held bundle
    task automatic waitIdle();
        do begin
            @(posedge clk);
            #10;
            outStall = 1'b0;
        end while (!lastReady);
    endtask

    initial begin
        logic [31:0] data;
        logic err;
        rstN = 1'b0;
        inBundle = '0;
        inValid = 1'b0;
        outStall = 1'b0;
        apbReq = '0;
        repeat (10) @(posedge clk);
        #10;
        rstN = 1'b1;
        @(negedge clk);
        assert (!issue[0].valid && !issue[1].valid && !redirect.flush && inReady)
            else failRun("outputs are not idle after reset");
        checkCounters();

        testName = "random";
        runBundles(150);
        waitIdle();
        testName = "noResolver";
        setCtrl(1'b0, 1'b0);
        runBundles(50);
        waitIdle();
        testName = "serializeAll";
        setCtrl(1'b1, 1'b1);
        runBundles(TOTAL_BUNDLES - 200);
        waitIdle();
        checkCounters();

        testName = "apbMap";
        apbRead(8'h0c, data, err);
        assert (err && data == '0)
            else failRun($sformatf("mismatch %s unknown address expected pslverr 1 actual %0b",
                testName, err));

        if (expQ.size() != 0 || flushQ.size() != 0) begin
            failRun("reference queue still holds entries at the end");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule
